// ==== Makefile ====
TOP := exStageTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wno-fatal -f project.f --top-module exStage
	verilator --lint-only --timing --assert -Wno-fatal -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== alu.sv ====
// Combinational ALU of the execute stage; picks operands and immediate extension from the opcode
module alu (
    input cpuPkg::instrOp instr,
    input cpuPkg::word dataRs,
    input cpuPkg::word dataRt,
    input logic [15:0] imm16,
    input logic [4:0] shamt,
    output cpuPkg::word result
);

    cpuPkg::instrFunc func;
    cpuPkg::word extImm;
    cpuPkg::word opB;
    logic [4:0] shiftAmt;
    logic zeroExt;

    instrClass cls (
        .instr(instr),
        .func(func),
        .mdStart(),
        .mdUnsigned()
    );

    // Leading run length of bitVal from 0 to 32
    function automatic cpuPkg::word countLeading(cpuPkg::word value, logic bitVal);
        cpuPkg::word count;
        logic done;
        count = '0;
        done = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (!done && value[i] == bitVal) begin
                count = count + 1'b1;
            end else begin
                done = 1'b1;
            end
        end
        return count;
    endfunction

    // Logic immediates are zero extended, everything else sign extended
    assign zeroExt = instr inside {cpuPkg::ANDI, cpuPkg::ORI, cpuPkg::XORI, cpuPkg::LUI};
    assign extImm = zeroExt ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};

    always_comb begin
        case (func)
            cpuPkg::FUNC_CALC_I, cpuPkg::FUNC_MEM_READ, cpuPkg::FUNC_MEM_WRITE: opB = extImm;
            cpuPkg::FUNC_CALC_R: opB = dataRt;
            default: opB = '0;
        endcase
    end

    // Fixed shifts use the shamt field, variable shifts the low bits of rs
    assign shiftAmt = (instr inside {cpuPkg::SLL, cpuPkg::SRL, cpuPkg::SRA}) ? shamt : dataRs[4:0];

    always_comb begin
        result = '0;
        if (func == cpuPkg::FUNC_MEM_READ || func == cpuPkg::FUNC_MEM_WRITE) begin
            // Effective address
            result = dataRs + opB;
        end else begin
            case (instr)
                cpuPkg::ADD, cpuPkg::ADDU, cpuPkg::ADDI, cpuPkg::ADDIU: result = dataRs + opB;
                cpuPkg::SUB, cpuPkg::SUBU: result = dataRs - opB;
                cpuPkg::AND, cpuPkg::ANDI: result = dataRs & opB;
                cpuPkg::OR, cpuPkg::ORI: result = dataRs | opB;
                cpuPkg::XOR, cpuPkg::XORI: result = dataRs ^ opB;
                cpuPkg::NOR: result = ~(dataRs | opB);
                cpuPkg::SLT, cpuPkg::SLTI: result = {31'b0, $signed(dataRs) < $signed(opB)};
                cpuPkg::SLTU, cpuPkg::SLTIU: result = {31'b0, dataRs < opB};
                cpuPkg::SLL, cpuPkg::SLLV: result = opB << shiftAmt;
                cpuPkg::SRL, cpuPkg::SRLV: result = opB >> shiftAmt;
                cpuPkg::SRA, cpuPkg::SRAV: result = $signed(opB) >>> shiftAmt;
                cpuPkg::LUI: result = {imm16, 16'b0};
                cpuPkg::CLO: result = countLeading(dataRs, 1'b1);
                cpuPkg::CLZ: result = countLeading(dataRs, 1'b0);
                default: result = '0;
            endcase
        end
    end

endmodule

// ==== cpuPkg.sv ====
// Shared widths, opcode and class enums and stage structs for the execute stage and its testbench
package cpuPkg;

    // Data and register widths
    typedef logic [31:0] word;
    typedef logic [4:0] regAddr;

    // Stages left until the result of an instruction exists
    typedef logic [1:0] tNewT;

    // Decoded instruction, as the decode stage hands it over
    typedef enum logic [5:0] {
        NOP = 6'd0,
        // ALU register ops
        ADD,
        ADDU,
        SUB,
        SUBU,
        AND,
        OR,
        XOR,
        NOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        SLLV,
        SRLV,
        SRAV,
        CLO,
        CLZ,
        // ALU immediate ops
        ADDI,
        ADDIU,
        ANDI,
        ORI,
        XORI,
        SLTI,
        SLTIU,
        LUI,
        // Loads and stores
        LW,
        SW,
        // HI/LO unit
        MULT,
        MULTU,
        DIV,
        DIVU,
        MADD,
        MADDU,
        MSUB,
        MSUBU,
        MFHI,
        MFLO,
        MTHI,
        MTLO,
        // Writes the link address, computed upstream
        JAL
    } instrOp;

    // Format class of an instruction
    typedef enum logic [2:0] {
        FUNC_NONE,
        FUNC_CALC_R,
        FUNC_CALC_I,
        FUNC_MEM_READ,
        FUNC_MEM_WRITE,
        FUNC_MULTDIV
    } instrFunc;

    // Contents of the decode/execute register
    typedef struct packed {
        instrOp instr;
        word pc;
        word dataRs;
        word dataRt;
        logic [15:0] imm16;
        logic [4:0] shamt;
        regAddr addrRs;
        regAddr addrRt;
        regAddr addrRd;
        regAddr regWriteAddr;
        word regWriteData;
        tNewT tNew;
    } exInput;

    // One forwarding source from a later stage
    typedef struct packed {
        regAddr addr;
        word data;
    } fwdSource;

    // Contents of the execute/memory register
    typedef struct packed {
        instrOp instr;
        word pc;
        word aluOut;
        regAddr addrRt;
        word dataRt;
        regAddr addrRd;
        regAddr regWriteAddr;
        word regWriteData;
        tNewT tNew;
    } exOutput;

endpackage

// ==== exStage.sv ====
// Top of the execute stage: forwarding, ALU and HI/LO unit, result select and execute/memory register
module exStage #(
    parameter int multCycles = 5,
    parameter int divCycles = 10
) (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic clear,
    input cpuPkg::exInput exIn,
    input cpuPkg::fwdSource fwdMem,
    input cpuPkg::fwdSource fwdWb,
    output cpuPkg::exOutput exOut,
    output logic mdBusy
);

    cpuPkg::word rsValue;
    cpuPkg::word rtValue;
    cpuPkg::word aluResult;
    cpuPkg::word hiLoOut;
    cpuPkg::word result;
    cpuPkg::word regWriteData;
    cpuPkg::tNewT tNew;
    cpuPkg::instrFunc func;
    cpuPkg::exOutput stageOut;
    logic issue;
    logic isMoveFrom;

    // Memory stage beats write-back, write-back beats the register file value
    function automatic cpuPkg::word forward(
        cpuPkg::regAddr addr,
        cpuPkg::word regValue,
        cpuPkg::fwdSource mem,
        cpuPkg::fwdSource wb
    );
        if (mem.addr == addr && mem.addr != '0) begin
            return mem.data;
        end else if (wb.addr == addr && wb.addr != '0) begin
            return wb.data;
        end
        return regValue;
    endfunction

    assign rsValue = forward(exIn.addrRs, exIn.dataRs, fwdMem, fwdWb);
    assign rtValue = forward(exIn.addrRt, exIn.dataRt, fwdMem, fwdWb);

    // An instruction leaves the stage only on an edge with neither stall nor clear
    assign issue = !stall && !clear;

    alu aluUnit (
        .instr(exIn.instr),
        .dataRs(rsValue),
        .dataRt(rtValue),
        .imm16(exIn.imm16),
        .shamt(exIn.shamt),
        .result(aluResult)
    );

    multDiv #(
        .multCycles(multCycles),
        .divCycles(divCycles)
    ) mdUnit (
        .clk(clk),
        .reset(reset),
        .issue(issue),
        .instr(exIn.instr),
        .dataRs(rsValue),
        .dataRt(rtValue),
        .hiLoOut(hiLoOut),
        .busy(mdBusy)
    );

    instrClass cls (
        .instr(exIn.instr),
        .func(func),
        .mdStart(),
        .mdUnsigned()
    );

    assign isMoveFrom = (exIn.instr == cpuPkg::MFHI) || (exIn.instr == cpuPkg::MFLO);
    assign result = isMoveFrom ? hiLoOut : aluResult;

    // Non-ALU writers such as JAL keep the value computed upstream
    always_comb begin
        if (isMoveFrom || func == cpuPkg::FUNC_CALC_R || func == cpuPkg::FUNC_CALC_I) begin
            regWriteData = result;
        end else begin
            regWriteData = exIn.regWriteData;
        end
    end

    // One stage closer to the result and floored at zero
    assign tNew = (exIn.tNew != '0) ? exIn.tNew - 1'b1 : '0;

    always_comb begin
        stageOut.instr = exIn.instr;
        stageOut.pc = exIn.pc;
        stageOut.aluOut = result;
        stageOut.addrRt = exIn.addrRt;
        stageOut.dataRt = rtValue;
        stageOut.addrRd = exIn.addrRd;
        stageOut.regWriteAddr = exIn.regWriteAddr;
        stageOut.regWriteData = regWriteData;
        stageOut.tNew = tNew;
    end

    // Clear loads a NOP bubble, stall holds the register
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            exOut <= '0;
        end else if (!stall) begin
            exOut <= stageOut;
        end
    end

    // Hazard unit never asks for a hold and a bubble in the same cycle
    stallClearExclusive: assert property (@(posedge clk) disable iff (reset)
        !(stall && clear))
        else $error("exStage: stall and clear high together");

endmodule

// ==== exStageTb.sv ====
// Directed testbench for the execute stage; simulation top, compiled with the RTL through project.f
module exStageTb;

    // About three times the summed length of all tests
    localparam int timeoutCycles = 1500;

    logic clk;
    logic reset;
    logic stall;
    logic clear;
    cpuPkg::exInput exIn;
    cpuPkg::fwdSource fwdMem;
    cpuPkg::fwdSource fwdWb;
    cpuPkg::exOutput exOut;
    logic mdBusy;

    logic [31:0] lfsrState = 32'he9ca_4f56;
    cpuPkg::word modelHi = '0;
    cpuPkg::word modelLo = '0;
    string testName;
    int errors = 0;
    int checks = 0;
    int testErrors = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    int cycles = 0;

    exStage #(
        .multCycles(5),
        .divCycles(10)
    ) dut_i (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .clear(clear),
        .exIn(exIn),
        .fwdMem(fwdMem),
        .fwdWb(fwdWb),
        .exOut(exOut),
        .mdBusy(mdBusy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic cpuPkg::word randBits(int n);
        cpuPkg::word value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'hD000_0001 : lfsrState >> 1;
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic cpuPkg::exInput randInstr(cpuPkg::instrOp op);
        cpuPkg::exInput ins;
        ins.instr = op;
        ins.pc = randBits(30) << 2;
        ins.dataRs = randBits(32);
        ins.dataRt = randBits(32);
        ins.imm16 = 16'(randBits(16));
        ins.shamt = 5'(randBits(5));
        ins.addrRs = 5'(randBits(5));
        ins.addrRt = 5'(randBits(5));
        ins.addrRd = 5'(randBits(5));
        ins.regWriteAddr = 5'(randBits(5));
        ins.regWriteData = randBits(32);
        ins.tNew = 2'(randBits(2));
        return ins;
    endfunction

    // Register 0 never forwards and the memory stage wins over write-back
    function automatic cpuPkg::word fwdValue(cpuPkg::regAddr addr, cpuPkg::word regVal,
                                             cpuPkg::fwdSource mem, cpuPkg::fwdSource wb);
        if (addr == 5'd0) return regVal;
        if (mem.addr == addr) return mem.data;
        if (wb.addr == addr) return wb.data;
        return regVal;
    endfunction

    function automatic cpuPkg::word leadCount(cpuPkg::word w, logic b);
        int n;
        n = 0;
        while (n < 32 && w[31 - n] == b) n++;
        return cpuPkg::word'(n);
    endfunction

    // Expected stage result from the ALU rules and the HI/LO model
    function automatic cpuPkg::word refAlu(cpuPkg::exInput ins, cpuPkg::word rs, cpuPkg::word rt);
        cpuPkg::word b;
        b = rt;
        if (ins.instr inside {cpuPkg::ANDI, cpuPkg::ORI, cpuPkg::XORI, cpuPkg::LUI}) begin
            b = {16'h0000, ins.imm16};
        end else if (ins.instr inside {[cpuPkg::ADDI:cpuPkg::SLTIU], cpuPkg::LW, cpuPkg::SW}) begin
            b = {{16{ins.imm16[15]}}, ins.imm16};
        end
        case (ins.instr)
            cpuPkg::ADD, cpuPkg::ADDU, cpuPkg::ADDI, cpuPkg::ADDIU: return rs + b;
            cpuPkg::LW, cpuPkg::SW: return rs + b;
            cpuPkg::SUB, cpuPkg::SUBU: return rs - b;
            cpuPkg::AND, cpuPkg::ANDI: return rs & b;
            cpuPkg::OR, cpuPkg::ORI: return rs | b;
            cpuPkg::XOR, cpuPkg::XORI: return rs ^ b;
            cpuPkg::NOR: return ~(rs | b);
            cpuPkg::SLT, cpuPkg::SLTI: return ($signed(rs) < $signed(b)) ? 32'd1 : 32'd0;
            cpuPkg::SLTU, cpuPkg::SLTIU: return (rs < b) ? 32'd1 : 32'd0;
            cpuPkg::SLL: return b << ins.shamt;
            cpuPkg::SRL: return b >> ins.shamt;
            cpuPkg::SRA: return $signed(b) >>> ins.shamt;
            cpuPkg::SLLV: return b << rs[4:0];
            cpuPkg::SRLV: return b >> rs[4:0];
            cpuPkg::SRAV: return $signed(b) >>> rs[4:0];
            cpuPkg::LUI: return {ins.imm16, 16'h0000};
            cpuPkg::CLO: return leadCount(rs, 1'b1);
            cpuPkg::CLZ: return leadCount(rs, 1'b0);
            cpuPkg::MFHI: return modelHi;
            cpuPkg::MFLO: return modelLo;
            default: return '0;
        endcase
    endfunction

    function automatic void updateModel(cpuPkg::instrOp op, cpuPkg::word rs, cpuPkg::word rt);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0] prod;
        logic [63:0] acc;
        sa = $signed(rs);
        sb = $signed(rt);
        prod = (op inside {cpuPkg::MULT, cpuPkg::MADD, cpuPkg::MSUB}) ?
            sa * sb : {32'b0, rs} * {32'b0, rt};
        acc = {modelHi, modelLo};
        case (op)
            cpuPkg::MULT, cpuPkg::MULTU: acc = prod;
            cpuPkg::MADD, cpuPkg::MADDU: acc = acc + prod;
            cpuPkg::MSUB, cpuPkg::MSUBU: acc = acc - prod;
            cpuPkg::DIV: acc = (rt == '0) ? {rs, 32'hFFFF_FFFF} :
                {$signed(rs) % $signed(rt), $signed(rs) / $signed(rt)};
            cpuPkg::DIVU: acc = (rt == '0) ? {rs, 32'hFFFF_FFFF} : {rs % rt, rs / rt};
            cpuPkg::MTHI: acc[63:32] = rs;
            cpuPkg::MTLO: acc[31:0] = rs;
            default: acc = {modelHi, modelLo};
        endcase
        {modelHi, modelLo} = acc;
    endfunction

    task automatic checkWord(string what, cpuPkg::word expected, cpuPkg::word actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s %s: expected %h, actual %h", testName, what, expected, actual);
        end
    endtask

    task automatic checkAddr(string what, cpuPkg::regAddr expected, cpuPkg::regAddr actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s %s: expected %0d, actual %0d", testName, what, expected, actual);
        end
    endtask

    task automatic checkBit(string what, logic expected, logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s %s: expected %b, actual %b", testName, what, expected, actual);
        end
    endtask

    task automatic startTest(string name);
        testName = name;
        testErrors = errors;
    endtask

    task automatic finishTest();
        if (errors == testErrors) begin
            testsPassed++;
            $display("PASS %s", testName);
        end else begin
            testsFailed++;
            $display("FAIL %s with %0d errors", testName, errors - testErrors);
        end
    endtask

    // Runs one instruction through the stage and checks it after the capturing edge
    task automatic runInstr(cpuPkg::exInput ins, cpuPkg::fwdSource mem, cpuPkg::fwdSource wb);
        cpuPkg::word rs;
        cpuPkg::word rt;
        cpuPkg::word expAlu;
        cpuPkg::word expWrite;
        cpuPkg::tNewT expTNew;
        string tag;
        tag = ins.instr.name();
        rs = fwdValue(ins.addrRs, ins.dataRs, mem, wb);
        rt = fwdValue(ins.addrRt, ins.dataRt, mem, wb);
        expAlu = refAlu(ins, rs, rt);
        expWrite = (ins.instr inside {[cpuPkg::ADD:cpuPkg::LUI], cpuPkg::MFHI, cpuPkg::MFLO}) ?
            expAlu : ins.regWriteData;
        expTNew = (ins.tNew == 2'd0) ? 2'd0 : ins.tNew - 2'd1;
        @(posedge clk);
        exIn <= ins;
        fwdMem <= mem;
        fwdWb <= wb;
        stall <= 1'b0;
        clear <= 1'b0;
        // Captured on this edge and followed by a NOP
        @(posedge clk);
        exIn <= '0;
        fwdMem <= '0;
        fwdWb <= '0;
        updateModel(ins.instr, rs, rt);
        @(negedge clk);
        checkWord({tag, " instr"}, cpuPkg::word'(ins.instr), cpuPkg::word'(exOut.instr));
        checkWord({tag, " aluOut"}, expAlu, exOut.aluOut);
        checkWord({tag, " regWriteData"}, expWrite, exOut.regWriteData);
        checkWord({tag, " dataRt"}, rt, exOut.dataRt);
        checkWord({tag, " pc"}, ins.pc, exOut.pc);
        checkAddr({tag, " addrRt"}, ins.addrRt, exOut.addrRt);
        checkAddr({tag, " addrRd"}, ins.addrRd, exOut.addrRd);
        checkAddr({tag, " regWriteAddr"}, ins.regWriteAddr, exOut.regWriteAddr);
        checkWord({tag, " tNew"}, cpuPkg::word'(expTNew), cpuPkg::word'(exOut.tNew));
    endtask

    task automatic testReset();
        startTest("reset");
        checkBit("exOut zero", 1'b1, exOut == '0);
        checkBit("mdBusy", 1'b0, mdBusy);
        runInstr(randInstr(cpuPkg::MFLO), '0, '0);
        finishTest();
    endtask

    task automatic testAluRandom();
        startTest("alu random");
        for (int i = int'(cpuPkg::ADD); i <= int'(cpuPkg::SW); i++) begin
            repeat (4) runInstr(randInstr(cpuPkg::instrOp'(i)), '0, '0);
        end
        finishTest();
    endtask

    task automatic testEdgeCases();
        cpuPkg::exInput ins;
        startTest("shift and count edges");
        ins = randInstr(cpuPkg::CLZ);
        ins.dataRs = '0;
        runInstr(ins, '0, '0);
        checkWord("clz of zero", 32'd32, exOut.aluOut);
        ins.instr = cpuPkg::CLO;
        ins.dataRs = '1;
        runInstr(ins, '0, '0);
        checkWord("clo of ones", 32'd32, exOut.aluOut);
        ins.dataRs = 32'hFFF0_0000;
        runInstr(ins, '0, '0);
        ins.instr = cpuPkg::SRA;
        ins.dataRt = 32'h8000_0000;
        ins.shamt = 5'd31;
        runInstr(ins, '0, '0);
        checkWord("sra sign fill", 32'hFFFF_FFFF, exOut.aluOut);
        // Only the low five bits of rs count
        ins.instr = cpuPkg::SLLV;
        ins.dataRs = 32'd36;
        runInstr(ins, '0, '0);
        ins.instr = cpuPkg::SW;
        ins.imm16 = 16'hFFFC;
        runInstr(ins, '0, '0);
        finishTest();
    endtask

    task automatic testForwarding();
        cpuPkg::exInput ins;
        cpuPkg::fwdSource mem;
        cpuPkg::fwdSource wb;
        startTest("forwarding");
        ins = randInstr(cpuPkg::SUB);
        ins.addrRs = 5'd5;
        ins.addrRt = 5'd9;
        mem = '{addr: 5'd5, data: randBits(32)};
        wb = '{addr: 5'd5, data: randBits(32)};
        runInstr(ins, mem, wb);
        checkWord("rt keeps register value", ins.dataRt, exOut.dataRt);
        wb.addr = 5'd9;
        runInstr(ins, mem, wb);
        checkWord("dataRt from wb", wb.data, exOut.dataRt);
        mem.addr = 5'd9;
        runInstr(ins, mem, wb);
        checkWord("dataRt from mem", mem.data, exOut.dataRt);
        ins.addrRt = 5'd0;
        mem.addr = 5'd0;
        wb.addr = 5'd0;
        runInstr(ins, mem, wb);
        checkWord("r0 not forwarded", ins.dataRt, exOut.dataRt);
        finishTest();
    endtask

    // Issue, count the busy cycles, then read HI and LO back
    task automatic mdIssue(cpuPkg::instrOp op, cpuPkg::word rs, cpuPkg::word rt, int busyLen);
        cpuPkg::exInput ins;
        int n;
        ins = randInstr(op);
        ins.dataRs = rs;
        ins.dataRt = rt;
        runInstr(ins, '0, '0);
        n = 0;
        while (mdBusy && n <= 20) begin
            n++;
            @(negedge clk);
        end
        if (mdBusy) $display("mdBusy did not fall after %s", op.name());
        checkWord({op.name(), " busy cycles"}, cpuPkg::word'(busyLen), cpuPkg::word'(n));
        runInstr(randInstr(cpuPkg::MFHI), '0, '0);
        runInstr(randInstr(cpuPkg::MFLO), '0, '0);
    endtask

    task automatic testMultDiv();
        startTest("multiply divide");
        mdIssue(cpuPkg::MULT, randBits(32), randBits(32), 5);
        mdIssue(cpuPkg::MULTU, randBits(32), randBits(32), 5);
        mdIssue(cpuPkg::DIV, randBits(32), randBits(32), 10);
        mdIssue(cpuPkg::DIVU, randBits(32), randBits(12), 10);
        mdIssue(cpuPkg::DIV, randBits(32), '0, 10);
        mdIssue(cpuPkg::DIVU, randBits(32), '0, 10);
        mdIssue(cpuPkg::MADD, randBits(32), randBits(32), 5);
        mdIssue(cpuPkg::MSUB, randBits(32), randBits(32), 5);
        mdIssue(cpuPkg::MSUBU, randBits(32), randBits(32), 5);
        mdIssue(cpuPkg::MTHI, randBits(32), '0, 0);
        mdIssue(cpuPkg::MTLO, randBits(32), '0, 0);
        finishTest();
    endtask

    task automatic testPipelineControl();
        cpuPkg::exInput ins;
        cpuPkg::exOutput held;
        startTest("pipeline control");
        ins = randInstr(cpuPkg::XOR);
        ins.tNew = 2'd0;
        runInstr(ins, '0, '0);
        ins.tNew = 2'd3;
        runInstr(ins, '0, '0);
        ins = randInstr(cpuPkg::JAL);
        runInstr(ins, '0, '0);
        checkWord("jal passthrough", ins.regWriteData, exOut.regWriteData);
        // Load the JAL again and freeze it behind a stall
        @(posedge clk);
        exIn <= ins;
        @(posedge clk);
        exIn <= randInstr(cpuPkg::ADD);
        stall <= 1'b1;
        @(negedge clk);
        held = exOut;
        checkWord("jal before stall", ins.regWriteData, held.regWriteData);
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            checkBit("stall holds exOut", 1'b1, exOut == held);
        end
        @(posedge clk);
        stall <= 1'b0;
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
        exIn <= '0;
        @(negedge clk);
        checkBit("clear gives bubble", 1'b1, exOut == '0);
        finishTest();
    endtask

    initial begin
        reset = 1'b1;
        stall = 1'b0;
        clear = 1'b0;
        exIn = '0;
        fwdMem = '0;
        fwdWb = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        testReset();
        testAluRandom();
        testEdgeCases();
        testForwarding();
        testMultDiv();
        testPipelineControl();
        $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
            testsPassed, testsFailed, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== instrClass.sv ====
// Decode table mapping an opcode to its format class and HI/LO unit role, shared by the stage blocks
module instrClass (
    input cpuPkg::instrOp instr,
    output cpuPkg::instrFunc func,
    output logic mdStart,
    output logic mdUnsigned
);

    always_comb begin
        case (instr)
            cpuPkg::ADD, cpuPkg::ADDU, cpuPkg::SUB, cpuPkg::SUBU,
            cpuPkg::AND, cpuPkg::OR, cpuPkg::XOR, cpuPkg::NOR,
            cpuPkg::SLT, cpuPkg::SLTU,
            cpuPkg::SLL, cpuPkg::SRL, cpuPkg::SRA,
            cpuPkg::SLLV, cpuPkg::SRLV, cpuPkg::SRAV,
            cpuPkg::CLO, cpuPkg::CLZ: begin
                func = cpuPkg::FUNC_CALC_R;
            end
            cpuPkg::ADDI, cpuPkg::ADDIU, cpuPkg::ANDI, cpuPkg::ORI,
            cpuPkg::XORI, cpuPkg::SLTI, cpuPkg::SLTIU, cpuPkg::LUI: begin
                func = cpuPkg::FUNC_CALC_I;
            end
            cpuPkg::LW: begin
                func = cpuPkg::FUNC_MEM_READ;
            end
            cpuPkg::SW: begin
                func = cpuPkg::FUNC_MEM_WRITE;
            end
            cpuPkg::MULT, cpuPkg::MULTU, cpuPkg::DIV, cpuPkg::DIVU,
            cpuPkg::MADD, cpuPkg::MADDU, cpuPkg::MSUB, cpuPkg::MSUBU,
            cpuPkg::MFHI, cpuPkg::MFLO, cpuPkg::MTHI, cpuPkg::MTLO: begin
                func = cpuPkg::FUNC_MULTDIV;
            end
            // NOP and JAL do nothing in the ALU
            default: begin
                func = cpuPkg::FUNC_NONE;
            end
        endcase
    end

    // Timed operations that occupy the unit
    always_comb begin
        case (instr)
            cpuPkg::MULT, cpuPkg::MULTU, cpuPkg::DIV, cpuPkg::DIVU,
            cpuPkg::MADD, cpuPkg::MADDU, cpuPkg::MSUB, cpuPkg::MSUBU: begin
                mdStart = 1'b1;
            end
            default: begin
                mdStart = 1'b0;
            end
        endcase
    end

    // Operands taken as unsigned
    always_comb begin
        case (instr)
            cpuPkg::MULTU, cpuPkg::DIVU, cpuPkg::MADDU, cpuPkg::MSUBU: begin
                mdUnsigned = 1'b1;
            end
            default: begin
                mdUnsigned = 1'b0;
            end
        endcase
    end

endmodule

// ==== multDiv.sv ====
// HI/LO multiply/divide unit; results commit at issue and a down-counter models occupancy
module multDiv #(
    parameter int multCycles = 5,
    parameter int divCycles = 10
) (
    input logic clk,
    input logic reset,
    input logic issue,
    input cpuPkg::instrOp instr,
    input cpuPkg::word dataRs,
    input cpuPkg::word dataRt,
    output cpuPkg::word hiLoOut,
    output logic busy
);

    localparam int maxCycles = (multCycles > divCycles) ? multCycles : divCycles;
    localparam int cntWidth = $clog2(maxCycles + 1);

    cpuPkg::word hi;
    cpuPkg::word lo;
    logic [cntWidth-1:0] count;
    logic mdStart;
    logic mdUnsigned;
    logic isDiv;
    logic [63:0] extRs;
    logic [63:0] extRt;
    logic [63:0] product;
    logic signed [32:0] divA;
    logic signed [32:0] divB;
    logic signed [32:0] quotient;
    logic signed [32:0] remainder;
    cpuPkg::word divLo;
    cpuPkg::word divHi;

    instrClass cls (
        .instr(instr),
        .func(),
        .mdStart(mdStart),
        .mdUnsigned(mdUnsigned)
    );

    assign isDiv = (instr == cpuPkg::DIV) || (instr == cpuPkg::DIVU);

    // Low 64 bits of the extended product are right for both signed and unsigned
    assign extRs = mdUnsigned ? {32'b0, dataRs} : {{32{dataRs[31]}}, dataRs};
    assign extRt = mdUnsigned ? {32'b0, dataRt} : {{32{dataRt[31]}}, dataRt};
    assign product = extRs * extRt;

    // One 33-bit signed divider serves DIV and DIVU, and avoids the min/-1 overflow
    assign divA = {~mdUnsigned & dataRs[31], dataRs};
    assign divB = {~mdUnsigned & dataRt[31], dataRt};
    assign quotient = (dataRt == '0) ? 33'sd0 : divA / divB;
    assign remainder = (dataRt == '0) ? 33'sd0 : divA % divB;

    // Divide by zero leaves LO all ones and HI equal to rs
    assign divLo = (dataRt == '0) ? '1 : quotient[31:0];
    assign divHi = (dataRt == '0) ? dataRs : remainder[31:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (issue) begin
            case (instr)
                cpuPkg::MULT, cpuPkg::MULTU: {hi, lo} <= product;
                cpuPkg::MADD, cpuPkg::MADDU: {hi, lo} <= {hi, lo} + product;
                cpuPkg::MSUB, cpuPkg::MSUBU: {hi, lo} <= {hi, lo} - product;
                cpuPkg::DIV, cpuPkg::DIVU: begin
                    hi <= divHi;
                    lo <= divLo;
                end
                cpuPkg::MTHI: hi <= dataRs;
                cpuPkg::MTLO: lo <= dataRs;
                default: begin
                end
            endcase
        end
    end

    // Occupancy counter loaded on a timed issue
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (issue && mdStart) begin
            count <= isDiv ? cntWidth'(divCycles) : cntWidth'(multCycles);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0);

    always_comb begin
        if (busy) begin
            hiLoOut = '0;
        end else if (instr == cpuPkg::MFHI) begin
            hiLoOut = hi;
        end else if (instr == cpuPkg::MFLO) begin
            hiLoOut = lo;
        end else begin
            hiLoOut = '0;
        end
    end

    // Hazard unit holds back timed ops while the unit is occupied
    noIssueWhileBusy: assert property (@(posedge clk) disable iff (reset)
        issue && mdStart |-> !busy)
        else $error("multDiv: timed instruction issued while busy");

    // Busy lasts exactly the configured latency after each start
    multOccupancy: assert property (@(posedge clk) disable iff (reset)
        issue && mdStart && !isDiv |=> busy [*multCycles] ##1 !busy)
        else $error("multDiv: multiply occupancy length wrong");

    divOccupancy: assert property (@(posedge clk) disable iff (reset)
        issue && mdStart && isDiv |=> busy [*divCycles] ##1 !busy)
        else $error("multDiv: divide occupancy length wrong");

endmodule

// ==== project.f ====
cpuPkg.sv
instrClass.sv
alu.sv
multDiv.sv
exStage.sv
exStageTb.sv
